// File: files.f
vec_pkg.sv
vec_pe_if.sv
vec_sequencer.sv
vec_lane.sv
vec_collector.sv
vec_top.sv
vec_top_sva.sv
tb_clock.sv
tb_vec_top.sv

// File: Makefile
# Verilator build and simulation of the vector engine testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, fail on a failing run"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_vec_top -Mdir obj_dir -f files.f
	./obj_dir/Vtb_vec_top > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log || ! grep -q '\*\* PASS \*\*' sim.log; then \
		echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: tb_vec_top.sv
`timescale 1ns/1ps
// Vector engine testbench
// Reference model, four-phase driver, answer compare process,
// directed tests, xorshift random stream and the closing report
module tb_vec_top;

  localparam int unsigned TIMEOUT_CYCLES = 400;

  logic           clk;
  logic           rst_n;
  logic           req;
  vec_pkg::vop_e  op;
  vec_pkg::vreg_t vd;
  vec_pkg::vreg_t vs1;
  vec_pkg::vreg_t vs2;
  logic           use_vs1;
  vec_pkg::elem_t scalar;
  vec_pkg::vl_t   vl;
  logic           ack;
  vec_pkg::elem_t scalar_out;
  logic           error_out;

  // Model register file with one slice per lane
  vec_pkg::elem_t ref_vrf [vec_pkg::NR_LANES][vec_pkg::NR_VREGS][vec_pkg::VLEN_LANE];
  // Expected answers in issue order
  vec_pkg::elem_t exp_scalar_q [$];
  logic           exp_error_q [$];
  string          exp_name_q [$];

  logic [31:0] rng_state;
  logic        ack_seen;
  logic        aborted;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;

  tb_clock #(.PeriodNs(20)) clk_gen_i (.clk_o(clk));

  vec_top dut_i (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .req_i     (req),
    .op_i      (op),
    .vd_i      (vd),
    .vs1_i     (vs1),
    .vs2_i     (vs2),
    .use_vs1_i (use_vs1),
    .scalar_i  (scalar),
    .vl_i      (vl),
    .ack_o     (ack),
    .scalar_o  (scalar_out),
    .error_o   (error_out)
  );

  bind vec_sequencer vec_top_sva sva_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .ack_i      (ack_q),
    .valid_i    (valid_q),
    .ready_i    (pe.pe_ready),
    .issue_id_i (req_q.id),
    .done_i     (vinsn_done_i)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Applies one instruction to the model and returns the expected scalar
  function automatic vec_pkg::elem_t ref_exec(vec_pkg::vop_e o, vec_pkg::vreg_t d,
                                              vec_pkg::vreg_t s1, vec_pkg::vreg_t s2,
                                              logic vv, vec_pkg::elem_t sc,
                                              vec_pkg::vl_t n);
    vec_pkg::elem_t a;
    vec_pkg::elem_t b;
    vec_pkg::elem_t sum;
    sum = '0;
    // Illegal lengths leave the registers alone
    if (n == '0 || n > vec_pkg::vl_t'(vec_pkg::VLEN_LANE))
      return sum;
    for (int l = 0; l < int'(vec_pkg::NR_LANES); l++) begin
      for (int e = 0; e < int'(n); e++) begin
        // Second operand is vs1 or the scalar, vs2 is always the first
        a = vv ? ref_vrf[l][s1][e] : sc;
        b = ref_vrf[l][s2][e];
        case (o)
          vec_pkg::VADD:   ref_vrf[l][d][e] = b + a;
          vec_pkg::VSUB:   ref_vrf[l][d][e] = b - a;
          vec_pkg::VXOR:   ref_vrf[l][d][e] = b ^ a;
          vec_pkg::VAND:   ref_vrf[l][d][e] = b & a;
          vec_pkg::VMUL:   ref_vrf[l][d][e] = b * a;
          vec_pkg::VSPLAT: ref_vrf[l][d][e] = sc;
          default:         sum = sum + b;
        endcase
      end
    end
    return sum;
  endfunction

  task automatic check_scalar(vec_pkg::elem_t got, vec_pkg::elem_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s returned scalar %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_error(logic got, logic exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s returned error flag %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Checks each answer against the oldest expectation as ack rises
  always @(negedge clk) begin : compare_proc
    if (ack && !ack_seen) begin
      if (exp_scalar_q.size() == 0) begin
        errors++;
        $display("ack raised at %0t with no request outstanding", $time);
      end else begin
        check_error(error_out, exp_error_q.pop_front(), exp_name_q[0]);
        check_scalar(scalar_out, exp_scalar_q.pop_front(), exp_name_q.pop_front());
      end
    end
    ack_seen = ack;
  end

  // Full four-phase transfer, called and returning on a falling edge
  task automatic transfer(vec_pkg::vop_e o, vec_pkg::vreg_t d, vec_pkg::vreg_t s1,
                          vec_pkg::vreg_t s2, logic vv, vec_pkg::elem_t sc,
                          vec_pkg::vl_t n);
    int unsigned cycles;
    if (aborted)
      return;
    exp_name_q.push_back($sformatf("%s vd %0d vs2 %0d vl %0d", o.name(), d, s2, n));
    exp_error_q.push_back(n == '0 || n > vec_pkg::vl_t'(vec_pkg::VLEN_LANE));
    exp_scalar_q.push_back(ref_exec(o, d, s1, s2, vv, sc, n));
    op      = o;
    vd      = d;
    vs1     = s1;
    vs2     = s2;
    use_vs1 = vv;
    scalar  = sc;
    vl      = n;
    req     = 1'b1;
    cycles  = 0;
    while (!ack && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    req = 1'b0;
    if (!ack) begin
      errors++;
      aborted = 1'b1;
      $display("handshake timed out at %0t, %s was never acknowledged", $time, o.name());
      return;
    end
    cycles = 0;
    while (ack && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (ack) begin
      errors++;
      aborted = 1'b1;
      $display("handshake timed out at %0t, ack stayed high after req dropped", $time);
    end
  endtask

  task automatic reduce(vec_pkg::vreg_t s2, vec_pkg::vl_t n);
    transfer(vec_pkg::VREDSUM, '0, '0, s2, 1'b0, '0, n);
  endtask

  task automatic splat(vec_pkg::vreg_t d, vec_pkg::elem_t value, vec_pkg::vl_t n);
    transfer(vec_pkg::VSPLAT, d, '0, '0, 1'b0, value, n);
  endtask

  task automatic close_test(string name, int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_start);
    end
  endtask

  task automatic reset_reductions();
    int err_start;
    err_start = errors;
    for (int r = 0; r < int'(vec_pkg::NR_VREGS); r++)
      reduce(vec_pkg::vreg_t'(r), 3'd4);
    close_test("reset reductions", err_start);
  endtask

  task automatic elementwise_ops();
    int            err_start;
    vec_pkg::vop_e op_k;
    err_start = errors;
    splat(3'd1, 16'h1234, 3'd4);
    splat(3'd2, 16'hf00d, 3'd4);
    // VADD to VMUL in vector-vector and vector-scalar form
    for (int k = 0; k < 5; k++) begin
      op_k = vec_pkg::vop_e'(k);
      transfer(op_k, 3'd3, 3'd1, 3'd2, 1'b1, 16'h0000, 3'd4);
      reduce(3'd3, 3'd4);
      transfer(op_k, 3'd4, 3'd0, 3'd2, 1'b0, 16'h0abc, 3'd3);
      reduce(3'd4, 3'd4);
    end
    close_test("elementwise ops", err_start);
  endtask

  task automatic hazard_chain();
    int err_start;
    err_start = errors;
    splat(3'd2, 16'h0007, 3'd4);
    splat(3'd3, 16'h0005, 3'd4);
    // Slow multiply into v1 then RAW, WAR and WAW back to back
    transfer(vec_pkg::VMUL, 3'd1, 3'd3, 3'd2, 1'b1, 16'h0000, 3'd4);
    transfer(vec_pkg::VADD, 3'd4, 3'd3, 3'd1, 1'b1, 16'h0000, 3'd4);
    splat(3'd2, 16'h0100, 3'd4);
    transfer(vec_pkg::VADD, 3'd1, 3'd0, 3'd3, 1'b0, 16'h0011, 3'd4);
    reduce(3'd1, 3'd4);
    reduce(3'd2, 3'd4);
    reduce(3'd4, 3'd4);
    // WAR and WAW again with the ALU idle, so only the hazard masks keep the order
    transfer(vec_pkg::VMUL, 3'd6, 3'd3, 3'd2, 1'b1, 16'h0000, 3'd4);
    splat(3'd2, 16'h0003, 3'd4);
    reduce(3'd6, 3'd4);
    transfer(vec_pkg::VMUL, 3'd6, 3'd3, 3'd2, 1'b1, 16'h0000, 3'd4);
    splat(3'd6, 16'h0042, 3'd4);
    reduce(3'd6, 3'd4);
    close_test("hazard chain", err_start);
  endtask

  task automatic illegal_lengths();
    int err_start;
    err_start = errors;
    splat(3'd5, 16'h0aa5, 3'd4);
    transfer(vec_pkg::VADD, 3'd5, 3'd1, 3'd2, 1'b1, 16'h0000, 3'd0);
    splat(3'd5, 16'hffff, 3'd5);
    transfer(vec_pkg::VMUL, 3'd5, 3'd5, 3'd5, 1'b1, 16'h0000, 3'd7);
    reduce(3'd5, 3'd0);
    // v5 must still hold the legal splat
    reduce(3'd5, 3'd4);
    close_test("illegal lengths", err_start);
  endtask

  task automatic random_stream();
    int             err_start;
    logic [31:0]    r;
    vec_pkg::vl_t   n;
    err_start = errors;
    for (int i = 0; i < 200; i++) begin
      r = next_rand();
      n = vec_pkg::vl_t'(int'(r[27:26]) + 1);
      if (i % 8 == 7)
        reduce(r[24:22], n);
      else
        transfer(vec_pkg::vop_e'(int'(r[31:28]) % 6), r[18:16], r[21:19], r[24:22],
                 r[25], r[15:0], n);
    end
    // Final sweep over the whole register file
    for (int v = 0; v < int'(vec_pkg::NR_VREGS); v++)
      reduce(vec_pkg::vreg_t'(v), 3'd4);
    close_test("random stream", err_start);
  endtask

  initial begin : main_proc
    rst_n        = 1'b0;
    req          = 1'b0;
    op           = vec_pkg::VADD;
    vd           = '0;
    vs1          = '0;
    vs2          = '0;
    use_vs1      = 1'b0;
    scalar       = '0;
    vl           = '0;
    rng_state    = 32'd87159;
    ack_seen     = 1'b0;
    aborted      = 1'b0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int l = 0; l < int'(vec_pkg::NR_LANES); l++)
      for (int r = 0; r < int'(vec_pkg::NR_VREGS); r++)
        for (int e = 0; e < int'(vec_pkg::VLEN_LANE); e++)
          ref_vrf[l][r][e] = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    reset_reductions();
    elementwise_ops();
    hazard_chain();
    illegal_lengths();
    random_stream();
    $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0 && !aborted)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule : tb_vec_top

// File: tb_clock.sv
`timescale 1ns/1ps
// Free-running testbench clock
module tb_clock #(
  parameter int unsigned PeriodNs = 20
) (
  output logic clk_o
);

  // Starts low and toggles every half period
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

endmodule : tb_clock

// File: vec_top_sva.sv
`timescale 1ns/1ps
// Sequencer assertions
// Four-phase ack, one-cycle broadcast after all-ready, free ID on issue
module vec_top_sva (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 req_i,
  input logic                 ack_i,
  input logic                 valid_i,
  input logic [vec_pkg::NR_LANES-1:0] ready_i,
  input vec_pkg::vid_t        issue_id_i,
  input vec_pkg::vinsn_mask_t done_i
);

  // IDs broadcast and not yet retired, tracked from the broadcast and done pulses
  vec_pkg::vinsn_mask_t inflight_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_q & ~done_i;
      if (valid_i)
        inflight_q[issue_id_i] <= 1'b1;
    end
  end

  // Ack only answers an open request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_i) |-> $past(req_i))
    else $error("ack rose while no request was open");

  // Broadcast is a single-cycle pulse
  valid_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |=> !valid_i)
    else $error("broadcast valid held for more than one cycle");

  // Every lane was ready in the cycle before the broadcast
  valid_after_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> $past(&ready_i))
    else $error("broadcast sent while a lane was not ready");

  // The broadcast ID has retired since it was last sent
  issue_id_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> !inflight_q[issue_id_i])
    else $error("instruction ID issued while still running");

endmodule : vec_top_sva

// File: vec_top.sv
`timescale 1ns/1ps
// Vector engine top level
// Sequencer, the generated lanes and the completion collector
module vec_top (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  vec_pkg::vop_e  op_i,
  input  vec_pkg::vreg_t vd_i,
  input  vec_pkg::vreg_t vs1_i,
  input  vec_pkg::vreg_t vs2_i,
  input  logic           use_vs1_i,
  input  vec_pkg::elem_t scalar_i,
  input  vec_pkg::vl_t   vl_i,
  output logic           ack_o,
  output vec_pkg::elem_t scalar_o,
  output logic           error_o
);

  vec_pe_req_if  pe_req_if ();
  vec_pe_resp_if pe_resp_if ();

  // Retirement and reduction result back to the sequencer
  vec_pkg::vinsn_mask_t vinsn_done;
  vec_pkg::elem_t       coll_scalar;
  logic                 coll_scalar_valid;

  vec_sequencer i_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .op_i           (op_i),
    .vd_i           (vd_i),
    .vs1_i          (vs1_i),
    .vs2_i          (vs2_i),
    .use_vs1_i      (use_vs1_i),
    .scalar_i       (scalar_i),
    .vl_i           (vl_i),
    .ack_o          (ack_o),
    .scalar_o       (scalar_o),
    .error_o        (error_o),
    .pe             (pe_req_if.seq),
    .vinsn_done_i   (vinsn_done),
    .scalar_i_coll  (coll_scalar),
    .scalar_valid_i (coll_scalar_valid)
  );

  for (genvar l = 0; l < vec_pkg::NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LaneIdx(l)
    ) i_lane (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .pe     (pe_req_if.lane),
      .resp   (pe_resp_if.lane)
    );
  end

  vec_collector i_collector (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .resp           (pe_resp_if.coll),
    .vinsn_done_o   (vinsn_done),
    .scalar_o       (coll_scalar),
    .scalar_valid_o (coll_scalar_valid)
  );

endmodule : vec_top

// File: vec_collector.sv
`timescale 1ns/1ps
// Completion collector
// Counts lane completions per ID, retires an ID once all lanes are done,
// and sums the lane partials of a reduction
module vec_collector (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  vec_pe_resp_if.coll          resp,
  output vec_pkg::vinsn_mask_t vinsn_done_o,
  output vec_pkg::elem_t       scalar_o,
  output logic                 scalar_valid_o
);

  typedef logic [$clog2(vec_pkg::NR_LANES+1)-1:0] cnt_t;

  cnt_t [vec_pkg::NR_VINSN-1:0] cnt_d, cnt_q;
  vec_pkg::vinsn_mask_t         done_d, done_q;
  vec_pkg::elem_t               sum_d, sum_q, scalar_q;
  vec_pkg::vid_t                red_id_d, red_id_q;
  logic                         red_act_d, red_act_q;
  logic                         red_ret, scalar_valid_q;

  always_comb begin
    cnt_d     = cnt_q;
    done_d    = '0;
    sum_d     = sum_q;
    red_id_d  = red_id_q;
    red_act_d = red_act_q;

    // Lanes finished per ID, retire at the full count
    for (int i = 0; i < vec_pkg::NR_VINSN; i++) begin
      for (int l = 0; l < vec_pkg::NR_LANES; l++)
        cnt_d[i] += cnt_t'(resp.pe_resp[l].done[i]);
      if (cnt_d[i] == cnt_t'(vec_pkg::NR_LANES)) begin
        done_d[i] = 1'b1;
        cnt_d[i]  = '0;
      end
    end

    // Only one reduction is in flight at a time
    for (int l = 0; l < vec_pkg::NR_LANES; l++) begin
      if (resp.pe_resp[l].partial_valid) begin
        sum_d     = sum_d + resp.pe_resp[l].partial;
        red_id_d  = resp.pe_resp[l].partial_id;
        red_act_d = 1'b1;
      end
    end
    red_ret = red_act_d && done_d[red_id_d];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q          <= '0;
      done_q         <= '0;
      sum_q          <= '0;
      red_id_q       <= '0;
      red_act_q      <= 1'b0;
      scalar_valid_q <= 1'b0;
    end else begin
      cnt_q          <= cnt_d;
      done_q         <= done_d;
      red_id_q       <= red_id_d;
      scalar_valid_q <= red_ret;
      // Start over once the total has gone out
      sum_q          <= red_ret ? '0 : sum_d;
      red_act_q      <= red_act_d && !red_ret;
    end
  end

  always_ff @(posedge clk_i) begin
    if (red_ret)
      scalar_q <= sum_d;
  end

  assign vinsn_done_o   = done_q;
  assign scalar_o       = scalar_q;
  assign scalar_valid_o = scalar_valid_q;

endmodule : vec_collector

// File: vec_lane.sv
`timescale 1ns/1ps
// One vector lane
// Register slice with two write ports, a small queue per unit,
// hazard-gated start and element-by-element execution
module vec_lane #(
  parameter int unsigned LaneIdx = 0
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  vec_pe_req_if.lane  pe,
  vec_pe_resp_if.lane resp
);

  typedef logic [$clog2(vec_pkg::UNIT_QDEPTH+1)-1:0] qcnt_t;

  vec_pkg::elem_t [vec_pkg::NR_VREGS-1:0][vec_pkg::VLEN_LANE-1:0] vrf_q;

  // Entry 0 of each queue is the instruction in execution
  vec_pkg::pe_req_t [vec_pkg::NR_UNITS-1:0][vec_pkg::UNIT_QDEPTH-1:0] q_d, q_q;
  qcnt_t [vec_pkg::NR_UNITS-1:0]            cnt_d, cnt_q;
  vec_pkg::pe_req_t [vec_pkg::NR_UNITS-1:0] head;
  vec_pkg::elem_t [vec_pkg::NR_UNITS-1:0]   opa, opb, res;
  vec_pkg::eidx_t [vec_pkg::NR_UNITS-1:0]   idx_q;
  logic [vec_pkg::NR_UNITS-1:0]             busy_q, phase_q;
  logic [vec_pkg::NR_UNITS-1:0]             start, step, last;
  logic                      ready;
  vec_pkg::elem_t            acc_q, partial_q;
  vec_pkg::vid_t             partial_id_q;
  logic                      partial_valid_q;
  vec_pkg::vinsn_mask_t      done_d, done_q;

  // Subtraction takes vs2 minus the other operand
  function automatic vec_pkg::elem_t elem_op(vec_pkg::vop_e op, vec_pkg::elem_t a,
                                             vec_pkg::elem_t b);
    case (op)
      vec_pkg::VADD: return b + a;
      vec_pkg::VSUB: return b - a;
      vec_pkg::VXOR: return b ^ a;
      vec_pkg::VAND: return b & a;
      vec_pkg::VMUL: return b * a;
      default:       return a;
    endcase
  endfunction

  // Room in both queues, so whatever comes can be taken
  always_comb begin
    ready = 1'b1;
    for (int u = 0; u < vec_pkg::NR_UNITS; u++)
      ready &= (cnt_q[u] < qcnt_t'(vec_pkg::UNIT_QDEPTH));
  end

  assign pe.pe_ready[LaneIdx] = ready;

  always_comb begin
    done_d = '0;
    for (int u = 0; u < vec_pkg::NR_UNITS; u++) begin
      head[u] = q_q[u][0];
      opb[u]  = vrf_q[head[u].vs2][idx_q[u]];
      opa[u]  = head[u].use_scalar ? head[u].scalar : vrf_q[head[u].vs1][idx_q[u]];
      res[u]  = elem_op(head[u].op, opa[u], opb[u]);
      // Head starts once none of its hazards is still running
      start[u] = (cnt_q[u] != '0) && !busy_q[u] &&
                 ~|((head[u].hazard_vs1 | head[u].hazard_vs2 |
                     head[u].hazard_vd | head[u].hazard_run) & pe.vinsn_running);
      // Multiplier writes every second cycle
      step[u] = busy_q[u] && ((u == int'(vec_pkg::ALU)) || phase_q[u]);
      last[u] = step[u] && (vec_pkg::vl_t'(idx_q[u]) + vec_pkg::vl_t'(1) == head[u].vl);
      if (last[u])
        done_d[head[u].id] = 1'b1;
    end
  end

  // Queue update
  always_comb begin
    q_d   = q_q;
    cnt_d = cnt_q;
    for (int u = 0; u < vec_pkg::NR_UNITS; u++) begin
      // Hazard bits of retired IDs are dropped so a reused ID is not waited on
      for (int e = 0; e < vec_pkg::UNIT_QDEPTH; e++) begin
        q_d[u][e].hazard_vs1 &= pe.vinsn_running;
        q_d[u][e].hazard_vs2 &= pe.vinsn_running;
        q_d[u][e].hazard_vd  &= pe.vinsn_running;
        q_d[u][e].hazard_run &= pe.vinsn_running;
      end
      if (last[u]) begin
        for (int e = 0; e < vec_pkg::UNIT_QDEPTH - 1; e++)
          q_d[u][e] = q_d[u][e+1];
        cnt_d[u] = cnt_d[u] - qcnt_t'(1);
      end
      if (pe.pe_valid && (pe.pe_req.unit == vec_pkg::vunit_e'(u))) begin
        q_d[u][cnt_d[u]] = pe.pe_req;
        cnt_d[u]         = cnt_d[u] + qcnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    q_q <= q_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q           <= '0;
      busy_q          <= '0;
      phase_q         <= '0;
      idx_q           <= '0;
      acc_q           <= '0;
      done_q          <= '0;
      partial_valid_q <= 1'b0;
    end else begin
      cnt_q           <= cnt_d;
      done_q          <= done_d;
      partial_valid_q <= last[vec_pkg::ALU] && (head[vec_pkg::ALU].op == vec_pkg::VREDSUM);
      for (int u = 0; u < vec_pkg::NR_UNITS; u++) begin
        if (start[u]) begin
          busy_q[u]  <= 1'b1;
          phase_q[u] <= 1'b0;
          idx_q[u]   <= '0;
        end else if (busy_q[u]) begin
          phase_q[u] <= !phase_q[u];
          if (step[u])
            idx_q[u] <= idx_q[u] + vec_pkg::eidx_t'(1);
          if (last[u])
            busy_q[u] <= 1'b0;
        end
      end
      // Reduction runs on the ALU only
      if (start[vec_pkg::ALU])
        acc_q <= '0;
      else if (step[vec_pkg::ALU] && head[vec_pkg::ALU].op == vec_pkg::VREDSUM)
        acc_q <= acc_q + opb[vec_pkg::ALU];
    end
  end

  // Lane partial sum including the last element
  always_ff @(posedge clk_i) begin
    if (last[vec_pkg::ALU]) begin
      partial_q    <= acc_q + opb[vec_pkg::ALU];
      partial_id_q <= head[vec_pkg::ALU].id;
    end
  end

  // Register slice, zero after reset, one write port per unit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vrf_q <= '0;
    end else begin
      for (int u = 0; u < vec_pkg::NR_UNITS; u++) begin
        if (step[u] && head[u].use_vd)
          vrf_q[head[u].vd][idx_q[u]] <= res[u];
      end
    end
  end

  assign resp.pe_resp[LaneIdx] = '{
    done:          done_q,
    partial:       partial_q,
    partial_id:    partial_id_q,
    partial_valid: partial_valid_q
  };

endmodule : vec_lane

// File: vec_sequencer.sv
`timescale 1ns/1ps
// Instruction sequencer
// Four-phase front end, ID allocation, register access lists,
// hazard masks and the broadcast of each request to the lanes
module vec_sequencer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  vec_pkg::vop_e        op_i,
  input  vec_pkg::vreg_t       vd_i,
  input  vec_pkg::vreg_t       vs1_i,
  input  vec_pkg::vreg_t       vs2_i,
  input  logic                 use_vs1_i,
  input  vec_pkg::elem_t       scalar_i,
  input  vec_pkg::vl_t         vl_i,
  output logic                 ack_o,
  output vec_pkg::elem_t       scalar_o,
  output logic                 error_o,
  vec_pe_req_if.seq            pe,
  input  vec_pkg::vinsn_mask_t vinsn_done_i,
  input  vec_pkg::elem_t       scalar_i_coll,
  input  logic                 scalar_valid_i
);

  // WAIT holds the handshake until a reduction result is back
  typedef enum logic {IDLE, WAIT} state_e;

  typedef struct packed {
    vec_pkg::vid_t vid;
    logic          valid;
  } vreg_access_t;

  state_e               state_d, state_q;
  logic                 ack_d, ack_q;
  logic                 error_d, error_q;
  vec_pkg::elem_t       scalar_d, scalar_q;
  vec_pkg::vinsn_mask_t running_d, running_q;
  vec_pkg::pe_req_t     req_d, req_q;
  logic                 valid_d, valid_q;
  vec_pkg::vid_t        next_id;
  logic                 id_free;
  logic                 vl_ok;
  logic                 use_vs2;

  // Last writer per register, last reader per register and unit
  vreg_access_t [vec_pkg::NR_VREGS-1:0]                        write_list_d, write_list_q;
  vreg_access_t [vec_pkg::NR_UNITS-1:0][vec_pkg::NR_VREGS-1:0] read_list_d, read_list_q;

  // Lowest free ID, a zero search over the running mask
  always_comb begin
    next_id = '0;
    id_free = 1'b0;
    for (int i = vec_pkg::NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        next_id = vec_pkg::vid_t'(i);
        id_free = 1'b1;
      end
    end
  end

  assign vl_ok   = (vl_i != '0) && (vl_i <= vec_pkg::vl_t'(vec_pkg::VLEN_LANE));
  assign use_vs2 = (op_i != vec_pkg::VSPLAT);

  always_comb begin
    state_d      = state_q;
    ack_d        = ack_q;
    error_d      = error_q;
    scalar_d     = scalar_q;
    req_d        = req_q;
    valid_d      = 1'b0;
    running_d    = running_q & ~vinsn_done_i;
    write_list_d = write_list_q;
    read_list_d  = read_list_q;

    // Forget accesses of retired IDs
    for (int v = 0; v < vec_pkg::NR_VREGS; v++) begin
      write_list_d[v].valid &= ~vinsn_done_i[write_list_q[v].vid];
      for (int u = 0; u < vec_pkg::NR_UNITS; u++)
        read_list_d[u][v].valid &= ~vinsn_done_i[read_list_q[u][v].vid];
    end

    if (ack_q) begin
      // Close the handshake once req_i is gone
      if (!req_i)
        ack_d = 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_i && !vl_ok) begin
            // Illegal length, answer without issuing
            ack_d    = 1'b1;
            error_d  = 1'b1;
            scalar_d = '0;
          end else if (req_i && (&pe.pe_ready) && id_free) begin
            req_d            = '0;
            req_d.id         = next_id;
            req_d.op         = op_i;
            req_d.unit       = vec_pkg::unit_of(op_i);
            req_d.vs1        = vs1_i;
            req_d.vs2        = vs2_i;
            req_d.vd         = vd_i;
            req_d.use_vs1    = use_vs1_i && use_vs2 && (op_i != vec_pkg::VREDSUM);
            req_d.use_scalar = !use_vs2 || (!use_vs1_i && op_i != vec_pkg::VREDSUM);
            req_d.use_vd     = (op_i != vec_pkg::VREDSUM);
            req_d.scalar     = scalar_i;
            req_d.vl         = vl_i;

            // RAW on each source
            if (req_d.use_vs1)
              req_d.hazard_vs1[write_list_d[vs1_i].vid] = write_list_d[vs1_i].valid;
            if (use_vs2)
              req_d.hazard_vs2[write_list_d[vs2_i].vid] = write_list_d[vs2_i].valid;

            if (req_d.use_vd) begin
              // WAW
              req_d.hazard_vd[write_list_d[vd_i].vid] = write_list_d[vd_i].valid;
              // WAR against the last reader on either unit
              for (int u = 0; u < vec_pkg::NR_UNITS; u++)
                req_d.hazard_run[read_list_d[u][vd_i].vid] |= read_list_d[u][vd_i].valid;
              write_list_d[vd_i] = '{vid: next_id, valid: 1'b1};
            end

            if (req_d.use_vs1)
              read_list_d[req_d.unit][vs1_i] = '{vid: next_id, valid: 1'b1};
            if (use_vs2)
              read_list_d[req_d.unit][vs2_i] = '{vid: next_id, valid: 1'b1};

            running_d[next_id] = 1'b1;
            valid_d            = 1'b1;
            error_d            = 1'b0;
            scalar_d           = '0;
            // Reductions answer only when their sum is back
            if (op_i == vec_pkg::VREDSUM)
              state_d = WAIT;
            else
              ack_d = 1'b1;
          end
        end
        WAIT: begin
          if (scalar_valid_i) begin
            state_d  = IDLE;
            ack_d    = 1'b1;
            scalar_d = scalar_i_coll;
          end
        end
        default: state_d = IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      ack_q        <= 1'b0;
      error_q      <= 1'b0;
      scalar_q     <= '0;
      valid_q      <= 1'b0;
      running_q    <= '0;
      write_list_q <= '0;
      read_list_q  <= '0;
    end else begin
      state_q      <= state_d;
      ack_q        <= ack_d;
      error_q      <= error_d;
      scalar_q     <= scalar_d;
      valid_q      <= valid_d;
      running_q    <= running_d;
      write_list_q <= write_list_d;
      read_list_q  <= read_list_d;
    end
  end

  // Broadcast payload, qualified by pe_valid
  always_ff @(posedge clk_i) begin
    req_q <= req_d;
  end

  assign pe.pe_req        = req_q;
  assign pe.pe_valid      = valid_q;
  assign pe.vinsn_running = running_q;

  assign ack_o    = ack_q;
  assign error_o  = error_q;
  assign scalar_o = scalar_q;

endmodule : vec_sequencer

// File: vec_pe_if.sv
`timescale 1ns/1ps
// Sequencer to lanes request broadcast
// Lanes to collector response
interface vec_pe_req_if;
  // Request is valid for one cycle only
  vec_pkg::pe_req_t     pe_req;
  logic                 pe_valid;
  // Live view of the running IDs
  vec_pkg::vinsn_mask_t vinsn_running;
  // One bit per lane, each lane drives its own
  wire [vec_pkg::NR_LANES-1:0] pe_ready;

  modport seq (
    output pe_req,
    output pe_valid,
    output vinsn_running,
    input  pe_ready
  );

  modport lane (
    input  pe_req,
    input  pe_valid,
    input  vinsn_running,
    output pe_ready
  );
endinterface : vec_pe_req_if

interface vec_pe_resp_if;
  // Done pulses and reduction partials of each lane
  vec_pkg::pe_resp_t pe_resp [vec_pkg::NR_LANES];

  modport lane (output pe_resp);
  modport coll (input pe_resp);
endinterface : vec_pe_resp_if

// File: vec_pkg.sv
// Vector engine definitions
// Sizes, ID and element types, operation and unit encodings,
// the request broadcast to the lanes and the lane response
package vec_pkg;

  localparam int unsigned NR_LANES    = 4;
  localparam int unsigned VLEN_LANE   = 4;
  localparam int unsigned NR_VREGS    = 8;
  localparam int unsigned NR_VINSN    = 4;
  localparam int unsigned ELEM_W      = 16;
  // ALU and multiplier
  localparam int unsigned NR_UNITS    = 2;
  localparam int unsigned UNIT_QDEPTH = 2;

  typedef logic [$clog2(NR_VINSN)-1:0]  vid_t;
  typedef logic [$clog2(NR_VREGS)-1:0]  vreg_t;
  // Legal lengths are 1 to VLEN_LANE
  typedef logic [$clog2(VLEN_LANE):0]   vl_t;
  // Element position inside a lane slice
  typedef logic [$clog2(VLEN_LANE)-1:0] eidx_t;
  typedef logic [ELEM_W-1:0]            elem_t;
  typedef logic [NR_VINSN-1:0]          vinsn_mask_t;

  typedef enum logic [2:0] {
    VADD, VSUB, VXOR, VAND, VMUL, VSPLAT, VREDSUM
  } vop_e;

  typedef enum logic {
    ALU, MUL
  } vunit_e;

  typedef struct packed {
    vid_t        id;
    vop_e        op;
    vunit_e      unit;
    vreg_t       vs1;
    vreg_t       vs2;
    vreg_t       vd;
    logic        use_vs1;
    logic        use_scalar;
    logic        use_vd;
    elem_t       scalar;
    vl_t         vl;
    // IDs that must retire before this one starts
    vinsn_mask_t hazard_vs1;
    vinsn_mask_t hazard_vs2;
    vinsn_mask_t hazard_vd;
    // Running readers of vd
    vinsn_mask_t hazard_run;
  } pe_req_t;

  typedef struct packed {
    vinsn_mask_t done;
    elem_t       partial;
    vid_t        partial_id;
    logic        partial_valid;
  } pe_resp_t;

  // Multiply goes to the slow unit, all else to the ALU
  function automatic vunit_e unit_of(vop_e op);
    return (op == VMUL) ? MUL : ALU;
  endfunction

endpackage : vec_pkg
